// ==== img_pkg.sv ====
package img_pkg;

	typedef logic [7:0]  pixel_t;	// one grayscale pixel.
	typedef logic [31:0] word_t;	// memory word, four pixels, msb byte first.
	typedef logic [6:0]  coord_t;	// row or column index into the line store.
	typedef logic [15:0] sum_t;	// patch sum, 256 * 255 fits.

	localparam int WIN      = 16;	// window edge in pixels.
	localparam int BUF_COLS = 80;	// line store width in pixels.

endpackage

// ==== ctrl_pkg.sv ====
package ctrl_pkg;

	// fetch sequencer, one command from accept to ack release.
	typedef enum logic [2:0] {
		seq_st_idle,		// waiting for cmd_req.
		seq_st_fetch,		// issuing band reads.
		seq_st_drain,		// last word lands in the store.
		seq_st_sum,		// adder running.
		seq_st_ack_hold		// result out, waiting for cmd_req low.
	} seq_state_t;

	typedef enum logic [1:0] {
		sum_st_idle,		// accumulator holds last result.
		sum_st_accumulate,	// one window row per cycle.
		sum_st_done		// single cycle done pulse.
	} sum_state_t;

endpackage

// ==== window_holder.sv ====
module window_holder import img_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  word_t  input_data,				// straight from memory read data.
	input  coord_t row,					// target row for a plain load.
	input  coord_t col,					// first of four target columns.
	input  logic   new_row,				// shift up, word goes to row 15 col 0.
	input  logic   load,					// store updates only on this.
	input  coord_t window_offset,				// left column of the output window.
	output pixel_t [WIN-1:0][WIN-1:0] window_data		// 16x16 patch with row 0 on top.
);

	pixel_t [WIN-1:0][BUF_COLS-1:0] store_q;		// 16 rows by 80 pixels.
	pixel_t [WIN-1:0][BUF_COLS-1:0] store_d;		// next store contents.

	// next store state puts the msb byte at the lowest column.
	always_comb begin
		store_d = store_q;				// default keep.
		if (new_row) begin
			for (int i = 0; i < WIN - 1; i++) begin
				store_d[i] = store_q[i+1];	// every row moves up one.
			end
			store_d[WIN-1] = '0;			// fresh bottom row.
			for (int b = 0; b < 4; b++) begin
				store_d[WIN-1][b] = input_data[31-8*b -: 8];	// first word of row.
			end
		end else begin
			for (int b = 0; b < 4; b++) begin
				store_d[row][col+b] = input_data[31-8*b -: 8];	// four bytes at col.
			end
		end
	end

	// line store written one word per load.
	always_ff @(posedge clk) begin
		if (load) begin
			store_q <= store_d;			// commit word.
		end
	end

	// window selected combinationally at the offset.
	always_comb begin
		for (int k = 0; k < WIN; k++) begin
			for (int m = 0; m < WIN; m++) begin
				window_data[k][m] = store_q[k][window_offset+m];	// column shift.
			end
		end
	end

	// sequencer must keep the window inside the store.
	a_window_in_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		(32'(window_offset) + WIN <= BUF_COLS)
	) else $error("window offset %0d past store edge", window_offset);

	// a loaded word must fit in the row.
	a_word_in_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		(load && !new_row) |-> (32'(col) + 3 < BUF_COLS)
	) else $error("word column %0d past store edge", col);

endmodule

// ==== fetch_sequencer.sv ====
module fetch_sequencer import img_pkg::*, ctrl_pkg::*; #(
	parameter int ROW_WORDS = 20,				// words per image row.
	parameter int IMG_ROWS  = 48,				// image height.
	parameter int ADDR_W    = 12				// memory address width.
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              cmd_req,			// four-phase request.
	input  coord_t            cmd_band,			// top image row of the strip.
	input  coord_t            cmd_offset,			// window column offset.
	output logic              cmd_ack,			// result valid while high.
	output logic              mem_rd,			// read strobe, data one cycle later.
	output logic [ADDR_W-1:0] mem_addr,
	output logic              load,				// store write enable.
	output logic              new_row,			// first word of a row.
	output coord_t            row,
	output coord_t            col,
	output coord_t            window_offset,		// latched offset for the store.
	output logic              sum_start,			// one cycle start to the adder.
	input  logic              sum_done
);

	localparam int WORD_W = (ROW_WORDS > 1) ? $clog2(ROW_WORDS) : 1;	// word counter width.

	seq_state_t        state_q;
	seq_state_t        state_d;
	coord_t            band_q;				// latched band.
	coord_t            offset_q;				// latched offset.
	logic [3:0]        row_cnt_q;				// row within the band.
	logic [WORD_W-1:0] word_cnt_q;				// word within the row.
	logic              last_word;
	logic              last_row;
	logic              accept;
	logic              load_q;				// load delayed to meet read data.
	logic              new_row_q;
	coord_t            col_q;
	logic [ADDR_W-1:0] row_base;				// image row being read.

	assign accept    = (state_q == seq_st_idle) && cmd_req;	// ack is low in idle.
	assign last_word = (word_cnt_q == WORD_W'(ROW_WORDS - 1));
	assign last_row  = (row_cnt_q == 4'(WIN - 1));

	always_comb begin
		state_d = state_q;
		case (state_q)
			seq_st_idle:
				if (cmd_req)
					state_d = seq_st_fetch;
			seq_st_fetch:
				if (last_word && last_row)
					state_d = seq_st_drain;	// final read issued.
			seq_st_drain:
				state_d = seq_st_sum;		// final word written this cycle.
			seq_st_sum:
				if (sum_done)
					state_d = seq_st_ack_hold;
			seq_st_ack_hold:
				if (!cmd_req)
					state_d = seq_st_idle;	// release, ready next cycle.
			default:
				state_d = seq_st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q    <= seq_st_idle;
			band_q     <= '0;
			offset_q   <= '0;
			row_cnt_q  <= '0;
			word_cnt_q <= '0;
			load_q     <= 1'b0;
			new_row_q  <= 1'b0;
			col_q      <= '0;
		end else begin
			state_q <= state_d;
			if (accept) begin
				band_q     <= cmd_band;		// hold for the whole command.
				offset_q   <= cmd_offset;
				row_cnt_q  <= '0;
				word_cnt_q <= '0;
			end else if (state_q == seq_st_fetch) begin
				if (last_word) begin
					word_cnt_q <= '0;		// wrap to next row.
					row_cnt_q  <= row_cnt_q + 4'd1;
				end else begin
					word_cnt_q <= word_cnt_q + 1'b1;
				end
			end
			load_q    <= mem_rd;				// one cycle memory latency.
			new_row_q <= mem_rd && (word_cnt_q == '0);
			col_q     <= coord_t'({word_cnt_q, 2'b00});	// four pixels per word.
		end
	end

	assign row_base = ADDR_W'(band_q) + ADDR_W'(row_cnt_q);
	assign mem_addr = row_base * ADDR_W'(ROW_WORDS) + ADDR_W'(word_cnt_q);	// row major.
	assign mem_rd   = (state_q == seq_st_fetch);

	assign load          = load_q;
	assign new_row       = new_row_q;
	assign row           = coord_t'(WIN - 1);		// plain loads always hit the bottom row.
	assign col           = col_q;
	assign window_offset = offset_q;
	assign sum_start     = (state_q == seq_st_drain);	// adder reads row 0 after the last write.
	assign cmd_ack       = (state_q == seq_st_ack_hold);

	// the band must lie inside the image.
	a_band_in_image: assert property (
		@(posedge clk) disable iff (!rst_n)
		accept |-> (32'(cmd_band) + WIN <= IMG_ROWS)
	) else $error("band %0d runs past image bottom", cmd_band);

	// client keeps the command stable until ack.
	a_cmd_stable: assert property (
		@(posedge clk) disable iff (!rst_n)
		(cmd_req && !cmd_ack) ##1 (cmd_req && !cmd_ack) |->
			($stable(cmd_band) && $stable(cmd_offset))
	) else $error("command changed before ack");

endmodule

// ==== patch_sum.sv ====
module patch_sum import img_pkg::*, ctrl_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   sum_start,				// clears and starts accumulation.
	input  pixel_t [WIN-1:0][WIN-1:0] window_data,		// patch from the store.
	output logic   sum_done,				// one cycle after the 16th row.
	output sum_t   sum_value				// held until the next start.
);

	sum_state_t state_q;
	logic [3:0] row_cnt_q;					// window row being added.
	sum_t       acc_q;					// running total.
	sum_t       row_sum;					// 16 pixels of the current row.

	// adder tree for one row with each pixel widened first.
	always_comb begin
		row_sum = '0;
		for (int m = 0; m < WIN; m++) begin
			row_sum = row_sum + sum_t'(window_data[row_cnt_q][m]);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q   <= sum_st_idle;
			row_cnt_q <= '0;
		end else begin
			case (state_q)
				sum_st_accumulate: begin
					row_cnt_q <= row_cnt_q + 4'd1;
					if (row_cnt_q == 4'(WIN - 1)) begin
						state_q <= sum_st_done;	// all rows in.
					end
				end
				default: begin				// idle or done.
					if (sum_start) begin
						state_q   <= sum_st_accumulate;
						row_cnt_q <= '0;
					end else begin
						state_q <= sum_st_idle;
					end
				end
			endcase
		end
	end

	// accumulator cleared on start.
	always_ff @(posedge clk) begin
		if (state_q != sum_st_accumulate && sum_start) begin
			acc_q <= '0;
		end else if (state_q == sum_st_accumulate) begin
			acc_q <= acc_q + row_sum;			// cannot overflow for 16 rows.
		end
	end

	assign sum_done  = (state_q == sum_st_done);
	assign sum_value = acc_q;

endmodule

// ==== patch_engine_top.sv ====
module patch_engine_top import img_pkg::*; #(
	parameter int ROW_WORDS = 20,				// image width is 4 * ROW_WORDS.
	parameter int IMG_ROWS  = 48,
	parameter int ADDR_W    = 12
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              cmd_req,
	input  coord_t            cmd_band,
	input  coord_t            cmd_offset,
	output logic              cmd_ack,
	output sum_t              result,			// patch sum, valid with cmd_ack.
	output logic              mem_rd,
	output logic [ADDR_W-1:0] mem_addr,
	input  word_t             mem_rdata			// one cycle after mem_rd.
);

	logic   load;
	logic   new_row;
	coord_t row;
	coord_t col;
	coord_t window_offset;
	logic   sum_start;
	logic   sum_done;
	pixel_t [WIN-1:0][WIN-1:0] window_data;

	fetch_sequencer #(
		.ROW_WORDS (ROW_WORDS),
		.IMG_ROWS  (IMG_ROWS),
		.ADDR_W    (ADDR_W)
	) u_seq (
		.clk, .rst_n,
		.cmd_req, .cmd_band, .cmd_offset, .cmd_ack,
		.mem_rd, .mem_addr,
		.load, .new_row, .row, .col, .window_offset,
		.sum_start, .sum_done
	);

	window_holder u_store (
		.clk, .rst_n,
		.input_data (mem_rdata),			// no extra register on read data.
		.row, .col, .new_row, .load, .window_offset,
		.window_data
	);

	patch_sum u_sum (
		.clk, .rst_n,
		.sum_start, .window_data,
		.sum_done,
		.sum_value (result)
	);

endmodule

// ==== tb_clock.sv ====
module tb_clock #(
	parameter int HALF_PERIOD  = 4,		// clock period is twice this.
	parameter int RESET_CYCLES = 3		// rising edges seen with rst_n low.
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// release on a falling edge, clear of the sampling edge.
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

// ==== tb_top.sv ====
module tb_top import img_pkg::*; ();

	localparam int ROW_WORDS = 20;				// image is 80 pixels wide.
	localparam int IMG_ROWS  = 48;
	localparam int ADDR_W    = 12;
	localparam int MEM_WORDS = IMG_ROWS * ROW_WORDS;
	localparam int MEM_AW    = $clog2(MEM_WORDS);
	localparam int WHITE_ROW = 32;				// rows from here down are all 0xff.
	localparam int TIMEOUT   = 1000;			// cycles allowed for any one wait.
	localparam int N_CMDS    = 7;
	localparam int CMD_AW    = $clog2(N_CMDS);
	localparam int MAX_SUM   = WIN * WIN * 255;		// a window of white pixels.

	logic              clk;
	logic              rst_n;
	logic              cmd_req;
	coord_t            cmd_band;
	coord_t            cmd_offset;
	logic              cmd_ack;
	sum_t              result;
	logic              mem_rd;
	logic [ADDR_W-1:0] mem_addr;
	word_t             mem_rdata = '0;

	word_t       mem [MEM_WORDS];				// row major image with the msb pixel first.

	// command table of band, offset, all-white flag and extra cycles with cmd_req held.
	coord_t band_tab   [N_CMDS] = '{7'd0, 7'd0, 7'd32, 7'd5, 7'd31, 7'd12, 7'd32};
	coord_t offset_tab [N_CMDS] = '{7'd0, 7'd64, 7'd0, 7'd17, 7'd63, 7'd40, 7'd64};
	logic   white_tab  [N_CMDS] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1};
	int     hold_tab   [N_CMDS] = '{0, 0, 0, 0, 0, 6, 3};

	tb_clock #(.HALF_PERIOD(4), .RESET_CYCLES(3)) u_clock (.clk, .rst_n);

	patch_engine_top #(
		.ROW_WORDS (ROW_WORDS),
		.IMG_ROWS  (IMG_ROWS),
		.ADDR_W    (ADDR_W)
	) uut (
		.clk, .rst_n,
		.cmd_req, .cmd_band, .cmd_offset, .cmd_ack, .result,
		.mem_rd, .mem_addr, .mem_rdata
	);

	// memory model returns read data one cycle after the strobe.
	always @(posedge clk) begin
		if (mem_rd) begin
			check_value("mem_addr below image size",
				32'(mem_addr < ADDR_W'(MEM_WORDS)), 32'd1);
			mem_rdata <= mem[MEM_AW'(mem_addr)];
		end
	end

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped on a failed check");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			stop_run($sformatf("[ERROR] %0t: %s is %0d, expected %0d",
				$time, what, got, exp));
		end
	endtask

	// returns on a falling edge with cmd_ack at the wanted level.
	task automatic wait_ack(input logic level, input string event_name);
		int cycles;
		cycles = 0;
		while (cmd_ack !== level) begin
			if (cycles == TIMEOUT) begin
				stop_run($sformatf("timeout: cmd_ack never %s within %0d cycles",
					event_name, TIMEOUT));
			end else begin
				@(negedge clk);
				cycles++;
			end
		end
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (rst_n !== 1'b1) begin
			if (cycles == TIMEOUT) begin
				stop_run("timeout: reset was never released");
			end else begin
				@(negedge clk);
				cycles++;
			end
		end
	endtask

	// sum of the 16x16 window taken straight from the image.
	function automatic int ref_sum(input int band, input int offset);
		int     total;
		int     c;
		word_t  w;
		pixel_t pix;
		total = 0;
		for (int r = 0; r < WIN; r++) begin
			for (int m = 0; m < WIN; m++) begin
				c     = offset + m;
				w     = mem[MEM_AW'((band + r) * ROW_WORDS + c / 4)];
				pix   = 8'(w >> (24 - 8 * (c % 4)));	// byte 0 is the msb.
				total = total + 32'(pix);
			end
		end
		return total;
	endfunction

	// one full four-phase exchange.
	task automatic run_command(input int num, input coord_t band, input coord_t offset,
			input logic white, input int hold);
		int expected;
		@(negedge clk);
		cmd_band   = band;
		cmd_offset = offset;
		cmd_req    = 1'b1;
		if (white) begin
			expected = MAX_SUM;
		end else begin
			expected = ref_sum(int'(band), int'(offset));
		end
		wait_ack(1'b1, "rose");
		check_value($sformatf("result of command %0d", num), 32'(result), expected);
		repeat (hold) begin
			@(negedge clk);				// client keeps cmd_req high.
			check_value("cmd_ack while cmd_req held", 32'(cmd_ack), 32'd1);
			check_value("result while cmd_req held", 32'(result), expected);
		end
		cmd_req = 1'b0;
		wait_ack(1'b0, "fell");
	endtask

	initial begin
		cmd_req    = 1'b0;
		cmd_band   = '0;
		cmd_offset = '0;
		void'($urandom(84));
		for (int i = 0; i < MEM_WORDS; i++) begin
			if (i / ROW_WORDS >= WHITE_ROW) begin
				mem[MEM_AW'(i)] = 32'hffff_ffff;	// white strip at the bottom.
			end else begin
				mem[MEM_AW'(i)] = $urandom();
			end
		end
		wait_reset_release();
		check_value("cmd_ack after reset", 32'(cmd_ack), 32'd0);
		check_value("mem_rd after reset", 32'(mem_rd), 32'd0);
		for (int i = 0; i < N_CMDS; i++) begin
			run_command(i, band_tab[CMD_AW'(i)], offset_tab[CMD_AW'(i)],
				white_tab[CMD_AW'(i)], hold_tab[CMD_AW'(i)]);
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== flist.f ====
img_pkg.sv
ctrl_pkg.sv
window_holder.sv
fetch_sequencer.sv
patch_sum.sv
patch_engine_top.sv
tb_clock.sv
tb_top.sv

// ==== Makefile ====
# Verilator build and run for the patch engine testbench.

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_top
OBJ_DIR   ?= obj_dir
FLIST     ?= flist.f

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
